/* common/quad_params.svh */
`ifndef QUAD_PARAMS_SVH
`define QUAD_PARAMS_SVH

//////////////////////////////////////////////////
// Data path widths
//////////////////////////////////////////////////

// Signed pixel and weight words
`define QUAD_PIXEL_WIDTH    16
`define QUAD_WEIGHT_WIDTH   16

// Accumulator, two and a half words
`define QUAD_ACC_WIDTH      40

// Result is the low word of the accumulator
`define QUAD_RESULT_WIDTH   16

//////////////////////////////////////////////////
// Storage depths
//////////////////////////////////////////////////
`define QUAD_MAX_KERNEL     16
`define QUAD_PFB_DEPTH      16
`define QUAD_RESULT_DEPTH   4

`endif

/* common/quad_pkg.sv */
`include "quad_params.svh"

package quad_pkg;

    // Stream words
    typedef logic signed [`QUAD_PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [`QUAD_WEIGHT_WIDTH-1:0] weight_t;
    typedef logic [`QUAD_RESULT_WIDTH-1:0]        result_t;

    // Running window sum
    typedef logic signed [`QUAD_ACC_WIDTH-1:0]    acc_t;

    // Job word, low bits of job_parameters
    //   [4:0]   kernel_size, 1 to 16
    //   [13:5]  num_windows
    //   [14]    relu_en
    typedef struct packed {
        logic       relu_en;
        logic [8:0] num_windows;
        logic [4:0] kernel_size;
    } job_params_t;

    // Job controller states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_FETCH_REQ = 3'd1,
        ST_FETCH     = 3'd2,
        ST_DRAIN     = 3'd3,
        ST_COMPLETE  = 3'd4
    } ctrl_state_t;

endpackage

/* hdl/prefetch_fifo.sv */
module prefetch_fifo #(
    parameter type payload_t = quad_pkg::pixel_t,
    parameter int  depth     = 4
) (
    input  logic                           clk_core,
    input  logic                           rst,
    input  logic                           push,
    input  payload_t                       push_data,
    input  logic                           pop,
    output payload_t                       pop_data,
    output logic                           empty,
    output logic                           full,
    output logic [$clog2(depth+1)-1:0]     count
);

    localparam int ptr_width = $clog2(depth);

    payload_t               mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic                   do_push;
    logic                   do_pop;

    // A full buffer still takes a push when the head leaves in the same cycle
    assign do_pop   = pop && !empty;
    assign do_push  = push && (!full || do_pop);

    assign empty    = (count == '0);
    assign full     = (count == depth);
    assign pop_data = mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_core) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

/* hdl/weight_table.sv */
`include "quad_params.svh"

module weight_table (
    input  logic                                clk_core,
    input  logic                                rst,
    input  logic                                wr_en,
    input  quad_pkg::weight_t                   wr_data,
    input  logic                                wr_restart,
    input  logic [$clog2(`QUAD_MAX_KERNEL)-1:0] rd_addr,
    output quad_pkg::weight_t                   rd_data
);

    import quad_pkg::*;

    localparam int addr_width = $clog2(`QUAD_MAX_KERNEL);

    weight_t                mem [`QUAD_MAX_KERNEL];
    logic [addr_width-1:0]  wr_ptr;

    // Write pointer, back to entry 0 for each new job
    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_restart) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Table storage, registered read
    //////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

/* hdl/mac_engine.sv */
`include "quad_params.svh"

module mac_engine (
    input  logic                                    clk_core,
    input  logic                                    rst,
    input  logic                                    job_active,
    input  quad_pkg::job_params_t                   cfg,
    input  logic                                    pfb_empty,
    input  quad_pkg::pixel_t                        pfb_data,
    output logic                                    pfb_pop,
    output logic [$clog2(`QUAD_MAX_KERNEL)-1:0]     weight_addr,
    input  quad_pkg::weight_t                       weight_data,
    input  logic [$clog2(`QUAD_RESULT_DEPTH+1)-1:0] res_count,
    output logic                                    res_push,
    output quad_pkg::result_t                       res_data,
    output logic                                    window_done
);

    import quad_pkg::*;

    localparam int tap_width = $clog2(`QUAD_MAX_KERNEL);

    logic [tap_width-1:0]                   tap;
    logic                                   tap_last;
    logic [$clog2(`QUAD_RESULT_DEPTH+1):0]  res_pending;
    pixel_t                                 relu_pixel;

    // Stage 1, popped pixel waiting for its weight
    logic                                   s1_valid;
    logic                                   s1_last;
    pixel_t                                 s1_pixel;

    // Stage 2, registered product
    logic                                   s2_valid;
    logic                                   s2_last;
    acc_t                                   s2_prod;

    acc_t                                   acc;
    acc_t                                   acc_sum;

    //////////////////////////////////////////////////
    // Pop control
    //////////////////////////////////////////////////

    // Results in the buffer plus window ends still in the pipeline
    assign res_pending = res_count
                       + (s1_valid && s1_last)
                       + (s2_valid && s2_last)
                       + res_push;

    assign pfb_pop     = job_active && !pfb_empty && (res_pending <= `QUAD_RESULT_DEPTH - 2);
    assign tap_last    = ({1'b0, tap} == cfg.kernel_size - 5'd1);
    assign weight_addr = tap;

    // ReLU clamps negative pixels to zero
    assign relu_pixel  = (cfg.relu_en && pfb_data[`QUAD_PIXEL_WIDTH-1]) ? '0 : pfb_data;

    assign acc_sum     = acc + s2_prod;
    assign window_done = res_push;

    //////////////////////////////////////////////////
    // Tap counter and valid flags
    //////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst || !job_active) begin
            tap      <= '0;
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
            acc      <= '0;
            res_push <= 1'b0;
        end else begin
            if (pfb_pop) begin
                tap <= tap_last ? '0 : tap + 1'b1;
            end
            s1_valid <= pfb_pop;
            s1_last  <= tap_last;
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
            res_push <= s2_valid && s2_last;

            // Sum restarts at zero after the last tap of a window
            if (s2_valid) begin
                acc <= s2_last ? '0 : acc_sum;
            end
        end
    end

    // Data path, weight arrives one cycle after the pop
    always_ff @(posedge clk_core) begin
        s1_pixel <= relu_pixel;
        s2_prod  <= s1_pixel * weight_data;
        res_data <= acc_sum[`QUAD_RESULT_WIDTH-1:0];
    end

endmodule

/* hdl/quad_ctrl.sv */
module quad_ctrl (
    input  logic                    clk_core,
    input  logic                    rst,
    input  logic                    job_start,
    input  logic [127:0]            job_parameters,
    output logic                    job_accept,
    output logic                    job_fetch_request,
    input  logic                    job_fetch_ack,
    input  logic                    job_fetch_complete,
    output logic                    job_complete,
    input  logic                    job_complete_ack,
    input  logic                    pixel_valid,
    input  logic                    pfb_full,
    output logic                    pfb_push,
    output logic                    pixel_ready,
    input  logic                    weight_valid,
    output logic                    weight_ready,
    input  logic                    window_done,
    input  logic                    res_empty,
    output logic                    job_active,
    output quad_pkg::job_params_t   cfg
);

    import quad_pkg::*;

    ctrl_state_t                        state;
    logic [$bits(cfg.num_windows)-1:0]  windows_seen;
    logic                               all_done;

    //////////////////////////////////////////////////
    // Stream ready signals
    //////////////////////////////////////////////////

    // Pixels only while fetching and the prefetch buffer has room
    assign pixel_ready  = (state == ST_FETCH) && pixel_valid && !pfb_full;
    assign pfb_push     = pixel_ready;

    // Weights load only between jobs
    assign weight_ready = (state == ST_IDLE) && weight_valid;

    // Every window counted and its result taken by the host
    assign all_done     = (windows_seen == cfg.num_windows) && res_empty;

    //////////////////////////////////////////////////
    // Job FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk_core) begin
        if (rst) begin
            state             <= ST_IDLE;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            job_active        <= 1'b0;
            windows_seen      <= '0;
        end else begin
            job_accept <= 1'b0;

            // Finished windows of the current job
            if (job_accept) begin
                windows_seen <= '0;
            end else if (window_done) begin
                windows_seen <= windows_seen + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_FETCH_REQ;
                    end
                end
                ST_FETCH_REQ: begin
                    // Active from here, in step with the registered job word
                    job_active <= 1'b1;
                    if (!job_fetch_request) begin
                        job_fetch_request <= 1'b1;
                    end else if (job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        state             <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (job_fetch_complete) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (all_done) begin
                        job_complete <= 1'b1;
                        state        <= ST_COMPLETE;
                    end
                end
                ST_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        job_active   <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Job word captured during the accept pulse
    always_ff @(posedge clk_core) begin
        if (job_accept) begin
            cfg <= job_params_t'(job_parameters[$bits(job_params_t)-1:0]);
        end
    end

endmodule

/* hdl/cnn_quad.sv */
`include "quad_params.svh"

module cnn_quad (
    input  logic                clk_core,
    input  logic                rst,

    // Job handshake
    input  logic                job_start,
    output logic                job_accept,
    input  logic [127:0]        job_parameters,
    output logic                job_fetch_request,
    input  logic                job_fetch_ack,
    input  logic                job_fetch_complete,
    output logic                job_complete,
    input  logic                job_complete_ack,

    // Kernel weights
    input  logic                weight_valid,
    output logic                weight_ready,
    input  logic [127:0]        weight_data,

    // Pixel stream
    input  logic                pixel_valid,
    output logic                pixel_ready,
    input  logic [127:0]        pixel_data,

    // Window results
    output logic                result_valid,
    input  logic                result_accept,
    output quad_pkg::result_t   result_data
);

    import quad_pkg::*;

    logic                                       job_active;
    job_params_t                                cfg;
    logic                                       pfb_push;
    logic                                       pfb_pop;
    logic                                       pfb_empty;
    logic                                       pfb_full;
    pixel_t                                     pfb_head;
    logic [$clog2(`QUAD_MAX_KERNEL)-1:0]        weight_addr;
    weight_t                                    weight_rd;
    logic                                       res_push;
    result_t                                    res_data;
    logic [$clog2(`QUAD_RESULT_DEPTH+1)-1:0]    res_count;
    logic                                       res_empty;
    logic                                       window_done;

    assign result_valid = !res_empty;

    //////////////////////////////////////////////////
    // Job control
    //////////////////////////////////////////////////
    quad_ctrl ctrl_i (
        .clk_core           (clk_core),
        .rst                (rst),
        .job_start          (job_start),
        .job_parameters     (job_parameters),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete       (job_complete),
        .job_complete_ack   (job_complete_ack),
        .pixel_valid        (pixel_valid),
        .pfb_full           (pfb_full),
        .pfb_push           (pfb_push),
        .pixel_ready        (pixel_ready),
        .weight_valid       (weight_valid),
        .weight_ready       (weight_ready),
        .window_done        (window_done),
        .res_empty          (res_empty),
        .job_active         (job_active),
        .cfg                (cfg)
    );

    // Weight ready is only high with a valid beat, so it doubles as the write strobe
    weight_table weight_table_i (
        .clk_core   (clk_core),
        .rst        (rst),
        .wr_en      (weight_ready),
        .wr_data    (weight_data[`QUAD_WEIGHT_WIDTH-1:0]),
        .wr_restart (job_accept),
        .rd_addr    (weight_addr),
        .rd_data    (weight_rd)
    );

    //////////////////////////////////////////////////
    // Pixel path and results
    //////////////////////////////////////////////////
    prefetch_fifo #(
        .payload_t  (pixel_t),
        .depth      (`QUAD_PFB_DEPTH)
    ) pixel_fifo (
        .clk_core   (clk_core),
        .rst        (rst),
        .push       (pfb_push),
        .push_data  (pixel_data[`QUAD_PIXEL_WIDTH-1:0]),
        .pop        (pfb_pop),
        .pop_data   (pfb_head),
        .empty      (pfb_empty),
        .full       (pfb_full),
        .count      ()
    );

    mac_engine mac_i (
        .clk_core    (clk_core),
        .rst         (rst),
        .job_active  (job_active),
        .cfg         (cfg),
        .pfb_empty   (pfb_empty),
        .pfb_data    (pfb_head),
        .pfb_pop     (pfb_pop),
        .weight_addr (weight_addr),
        .weight_data (weight_rd),
        .res_count   (res_count),
        .res_push    (res_push),
        .res_data    (res_data),
        .window_done (window_done)
    );

    // Pop is ignored while empty, so result_accept alone drives it
    prefetch_fifo #(
        .payload_t  (result_t),
        .depth      (`QUAD_RESULT_DEPTH)
    ) result_fifo (
        .clk_core   (clk_core),
        .rst        (rst),
        .push       (res_push),
        .push_data  (res_data),
        .pop        (result_accept),
        .pop_data   (result_data),
        .empty      (res_empty),
        .full       (),
        .count      (res_count)
    );

endmodule

/* verification/cnn_quad_tb.sv */
module cnn_quad_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import quad_pkg::*;

    localparam int max_tests = 8;

    logic               clk_core = 1'b0;
    logic               rst;
    logic               job_start;
    logic               job_accept;
    logic [127:0]       job_parameters;
    logic               job_fetch_request;
    logic               job_fetch_ack;
    logic               job_fetch_complete;
    logic               job_complete;
    logic               job_complete_ack;
    logic               weight_valid;
    logic               weight_ready;
    logic [127:0]       weight_data;
    logic               pixel_valid;
    logic               pixel_ready;
    logic [127:0]       pixel_data;
    logic               result_valid;
    logic               result_accept;
    result_t            result_data;

    // Stimulus records, list kind 0 weights, 1 pixels, 2 expected results
    logic [8*24-1:0]    test_name [max_tests];
    int                 test_stall [max_tests];
    int                 test_kernel [max_tests];
    int                 test_windows [max_tests];
    int                 test_relu [max_tests];
    int                 list_first [max_tests][3];
    int                 list_count [max_tests][3];
    logic [15:0]        values [$];

    int                 num_tests;
    int                 total_pixels;
    bit                 file_ok;
    int                 cycles = 0;
    int                 cycle_limit = 1000000;
    int                 accept_total = 0;
    int                 test_errors;
    int                 pass_count = 0;
    int                 fail_count = 0;

    cnn_quad cnn_quad_i (.*);

    always #50 clk_core = ~clk_core;

    // Cycle budget and accept pulse count
    always @(negedge clk_core) begin
        cycles = cycles + 1;
        if (job_accept) begin
            accept_total = accept_total + 1;
        end
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////
    task automatic report_value(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Fail %0s: expected 0x%0h, got 0x%0h", sig, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %0s", msg);
        test_errors++;
    endtask

    task automatic close_test(input logic [8*24-1:0] name);
        if (test_errors == 0) begin
            pass_count++;
            $display("Test %0s passed", name);
        end else begin
            fail_count++;
            $display("Test %0s failed with %0d errors", name, test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////
    task automatic read_stimulus();
        int                 fd;
        int                 code;
        int                 n;
        int                 kind;
        int                 i;
        int                 cur;
        logic [8*24-1:0]    tok;
        logic [8*100-1:0]   rest;
        logic [15:0]        val;

        fd = $fopen("verification/quad_stimulus.txt", "r");
        file_ok = (fd != 0);
        num_tests = 0;
        total_pixels = 0;
        while (file_ok && !$feof(fd)) begin
            tok = '0;
            kind = -1;
            cur = num_tests - 1;
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(rest, fd);
                end else if (tok == "test") begin
                    code = $fscanf(fd, "%s %d", test_name[num_tests], test_stall[num_tests]);
                    num_tests++;
                end else if (tok == "job") begin
                    code = $fscanf(fd, "%d %d %d", test_kernel[cur], test_windows[cur],
                                   test_relu[cur]);
                end else if (tok == "weights") begin
                    kind = 0;
                end else if (tok == "pixels") begin
                    kind = 1;
                end else if (tok == "expect") begin
                    kind = 2;
                end else begin
                    file_ok = 1'b0;
                end
            end
            if (kind >= 0) begin
                code = $fscanf(fd, "%d", n);
                list_first[cur][kind] = values.size();
                list_count[cur][kind] = n;
                for (i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", val);
                    values.push_back(val);
                end
                if (kind == 1) begin
                    total_pixels += n;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // Outputs idle after reset, even with a pixel offered
    task automatic check_reset();
        test_errors = 0;
        pixel_valid = 1'b1;
        #1;
        if (job_accept !== 1'b0) report_value("job_accept", 0, job_accept);
        if (job_fetch_request !== 1'b0) report_value("job_fetch_request", 0, job_fetch_request);
        if (job_complete !== 1'b0) report_value("job_complete", 0, job_complete);
        if (result_valid !== 1'b0) report_value("result_valid", 0, result_valid);
        if (pixel_ready !== 1'b0) report_value("pixel_ready", 0, pixel_ready);
        if (weight_ready !== 1'b0) report_value("weight_ready", 0, weight_ready);
        @(negedge clk_core);
        pixel_valid = 1'b0;
        close_test("reset_state");
    endtask

    //////////////////////////////////////////////////
    // One job from weights to completion
    //////////////////////////////////////////////////
    task automatic run_job(input int t);
        job_params_t    params;
        int             idx;
        int             waited;
        int             limit;
        int             sent;
        int             got;
        int             accept_base;
        bit             early_complete;
        logic [15:0]    expected;

        test_errors = 0;
        limit = 40 * list_count[t][1] + 100;

        // Weights go in while the controller is idle
        for (idx = 0; idx < list_count[t][0]; idx++) begin
            @(negedge clk_core);
            weight_valid = 1'b1;
            weight_data = {112'd0, values[list_first[t][0] + idx]};
            #1;
            if (weight_ready !== 1'b1) report_value("weight_ready", 1, weight_ready);
        end
        @(negedge clk_core);
        weight_valid = 1'b0;
        #1;
        if (weight_ready !== 1'b0) report_value("weight_ready", 0, weight_ready);

        params.kernel_size = 5'(test_kernel[t]);
        params.num_windows = 9'(test_windows[t]);
        params.relu_en = test_relu[t][0];
        @(negedge clk_core);
        job_parameters = '0;
        job_parameters[$bits(job_params_t)-1:0] = params;
        job_start = 1'b1;
        #1;
        accept_base = accept_total;
        waited = 0;
        while (!job_accept && waited < 10) begin
            @(negedge clk_core);
            #1;
            waited++;
        end
        if (!job_accept) begin
            job_start = 1'b0;
            report_problem("job_accept never pulsed");
            close_test(test_name[t]);
            return;
        end
        @(negedge clk_core);
        job_start = 1'b0;

        // Fetch request is held until the ack
        #1;
        waited = 0;
        while (!job_fetch_request && waited < 10) begin
            @(negedge clk_core);
            #1;
            waited++;
        end
        if (!job_fetch_request) begin
            report_problem("job_fetch_request never rose");
            close_test(test_name[t]);
            return;
        end
        repeat (2) begin
            @(negedge clk_core);
            #1;
            if (!job_fetch_request) report_problem("job_fetch_request fell before the ack");
        end
        @(negedge clk_core);
        job_fetch_ack = 1'b1;
        @(negedge clk_core);
        job_fetch_ack = 1'b0;
        #1;
        if (job_fetch_request) report_problem("job_fetch_request stayed high after the ack");

        sent = 0;
        got = 0;
        early_complete = 1'b0;
        fork
            begin
                // Gapped pixel stream, then the fetch complete pulse
                waited = 0;
                while (sent < list_count[t][1] && waited < limit) begin
                    @(negedge clk_core);
                    pixel_valid = ($urandom % 4) != 0;
                    pixel_data = {112'd0, values[list_first[t][1] + sent]};
                    #1;
                    if (pixel_valid && pixel_ready) begin
                        sent++;
                    end
                    waited++;
                end
                @(negedge clk_core);
                pixel_valid = 1'b0;
                job_fetch_complete = 1'b1;
                @(negedge clk_core);
                job_fetch_complete = 1'b0;
            end
            begin
                // Results in order, with random stalls where the test asks
                idx = 0;
                while (got < list_count[t][2] && idx < limit) begin
                    @(negedge clk_core);
                    result_accept = (test_stall[t] != 0) ? (($urandom % 3) == 0) : 1'b1;
                    #1;
                    if (job_complete) begin
                        early_complete = 1'b1;
                    end
                    if (result_valid && result_accept) begin
                        expected = values[list_first[t][2] + got];
                        if (result_data !== expected) begin
                            report_value("result_data", expected, result_data);
                        end
                        got++;
                    end
                    idx++;
                end
                @(negedge clk_core);
                result_accept = 1'b0;
            end
        join
        if (sent != list_count[t][1]) begin
            report_problem($sformatf("only %0d of %0d pixel beats were taken", sent,
                                     list_count[t][1]));
        end
        if (got != list_count[t][2]) begin
            report_problem($sformatf("only %0d of %0d results arrived", got,
                                     list_count[t][2]));
        end
        if (early_complete) report_problem("job_complete rose before every result was taken");

        // Completion level, held until the ack
        #1;
        waited = 0;
        while (!job_complete && waited < 20) begin
            @(negedge clk_core);
            #1;
            waited++;
        end
        if (!job_complete) begin
            report_problem("job_complete never rose");
        end else begin
            if (result_valid) report_problem("an extra result was left in the result buffer");
            repeat (2) begin
                @(negedge clk_core);
                #1;
                if (!job_complete) report_problem("job_complete fell before the ack");
            end
            @(negedge clk_core);
            job_complete_ack = 1'b1;
            @(negedge clk_core);
            job_complete_ack = 1'b0;
            #1;
            if (job_complete) report_problem("job_complete stayed high after the ack");
        end
        if (accept_total - accept_base != 1) begin
            report_problem($sformatf("job_accept pulsed %0d times", accept_total - accept_base));
        end
        close_test(test_name[t]);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int t;

        void'($urandom(12));
        rst = 1'b1;
        job_start = 1'b0;
        job_parameters = '0;
        job_fetch_ack = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack = 1'b0;
        weight_valid = 1'b0;
        weight_data = '0;
        pixel_valid = 1'b0;
        pixel_data = '0;
        result_accept = 1'b0;

        read_stimulus();
        cycle_limit = 40 * total_pixels + 200;

        repeat (2) @(negedge clk_core);
        rst = 1'b0;
        check_reset();

        if (!file_ok || num_tests == 0) begin
            $display("Error: the stimulus file could not be read");
            fail_count++;
        end else begin
            for (t = 0; t < num_tests; t++) begin
                run_job(t);
            end
        end

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verification/quad_stimulus.txt */
# Each test has five records: test <name> <stall> ; weights <n> <hex values> ;
# job <kernel_size> <num_windows> <relu_en> ; pixels <n> <hex values> ; expect <n> <hex results>
test relu_off_k3 0
weights 3 0002 fffd 0001
job 3 2 0
pixels 6 0005 fffe 0003 fff9 0004 0002
expect 2 0013 ffe8
test relu_on_k3 0
weights 3 0002 fffd 0001
job 3 2 1
pixels 6 0005 fffe 0003 fff9 0004 0002
expect 2 000d fff6
test wrap_k16 0
weights 16 0064 ff38 012c fe70 01f4 fda8 02bc fce0 03e8 07d0 f448 0fa0 0032 ffc4 0046 7530
job 16 2 0
pixels 32
03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8 03e8
ff9c ff38 fed4 fe70 fe0c fda8 fd44 fce0 fc7c fc18 fbb4 fb50 faec fa88 fa24 f9c0
expect 2 9c60 9ed0
test stall_k2 1
weights 2 0003 ffff
job 2 4 0
pixels 8 000a 0014 fffb 0007 0064 0001 7fff 7fff
expect 4 000a ffea 012b fffe

/* src.f */
+incdir+common
common/quad_pkg.sv
hdl/prefetch_fifo.sv
hdl/weight_table.sv
hdl/mac_engine.sv
hdl/quad_ctrl.sv
hdl/cnn_quad.sv
verification/cnn_quad_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the cnn_quad testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module cnn_quad_tb -f src.f -o cnn_quad_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/cnn_quad_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
